/* Bender.yml */
package:
  name: idct_stage

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/idct_pkg.sv
      - verilog/dp_ram.sv
      - idct/idct_block_fetch.sv
      - idct/idct_mac.sv
      - idct/idct_writeback.sv
      - verilog/idct_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - verif/tb_idct.sv

/* common/idct_config.svh */
// IDCT stage dimensions
`ifndef IDCT_CONFIG_SVH
`define IDCT_CONFIG_SVH

// plane size in pixels, multiples of 8
`define IDCT_IMG_W 16
`define IDCT_IMG_H 8
`define IDCT_BLK_COLS (`IDCT_IMG_W / 8)
`define IDCT_BLK_ROWS (`IDCT_IMG_H / 8)

// sram word addresses
`define IDCT_PRE_BASE 18'd76800
`define IDCT_OUT_BASE 18'd0

// shifts after each pass
`define IDCT_T_SHIFT 8
`define IDCT_S_SHIFT 16

`endif

/* common/idct_pkg.sv */
// IDCT shared types and cosine table
package idct_pkg;

	typedef logic signed [15:0] coef_t;
	typedef logic signed [31:0] acc_t;
	typedef logic [17:0] sram_addr_t;

	// C[i][j] scaled by 4096, row i is the frequency index
	function automatic coef_t c_value(input logic [2:0] i, input logic [2:0] j);
		logic [6:0] prod;
		logic [4:0] f;
		logic neg;
		coef_t mag;
		prod = {3'b000, j, 1'b1} * {4'b0000, i};
		// fold the angle (2j+1)i*pi/16 into the first quadrant
		f = (prod[4:0] > 5'd16) ? 5'd0 - prod[4:0] : prod[4:0];
		neg = (f > 5'd8);
		if (neg) begin
			f = 5'd16 - f;
		end
		case (f)
			5'd1: mag = 16'sd2008;
			5'd2: mag = 16'sd1892;
			5'd3: mag = 16'sd1702;
			5'd4: mag = 16'sd1448;
			5'd5: mag = 16'sd1137;
			5'd6: mag = 16'sd783;
			5'd7: mag = 16'sd399;
			default: mag = 16'sd0;
		endcase
		if (i == 3'd0) begin
			return 16'sd1448;
		end
		return neg ? -mag : mag;
	endfunction

endpackage

/* flist.f */
+incdir+common
common/idct_pkg.sv
verilog/dp_ram.sv
idct/idct_block_fetch.sv
idct/idct_mac.sv
idct/idct_writeback.sv
verilog/idct_top.sv
verif/tb_idct.sv

/* idct/idct_block_fetch.sv */
// Block sequencer and coefficient fetch
`timescale 1ns/1ps
`include "idct_config.svh"

module idct_block_fetch (
	input  logic                  Clock,
	input  logic                  Resetn,
	input  logic                  start_i,
	input  logic                  wb_done_i,
	input  idct_pkg::coef_t       sram_rdata_i,
	output idct_pkg::sram_addr_t  fetch_sram_addr_o,
	output logic                  buf_we_o,
	output logic [5:0]            buf_waddr_o,
	output idct_pkg::coef_t       buf_wdata_o,
	output logic                  fetch_done_o,
	output logic                  done_o
);

	logic busy_q;
	logic iss_on_q;
	logic [5:0] cnt_q;
	logic [7:0] blk_col_q;
	logic [7:0] blk_row_q;
	idct_pkg::sram_addr_t blk_base_q;
	idct_pkg::sram_addr_t row_base_q;
	idct_pkg::sram_addr_t next_base;
	idct_pkg::sram_addr_t iss_addr;
	logic last_col;
	logic last_blk;
	logic kick;
	logic iss_now;
	logic [5:0] iss_idx;
	// sram latency line, one entry per cycle
	logic [2:0] dl_v_q;
	logic [5:0] dl_idx_q [3];

	assign last_col = (blk_col_q == 8'(`IDCT_BLK_COLS - 1));
	assign last_blk = last_col && (blk_row_q == 8'(`IDCT_BLK_ROWS - 1));
	assign kick = (start_i && !busy_q) || (wb_done_i && busy_q && !last_blk);
	assign iss_now = kick || iss_on_q;
	assign iss_idx = kick ? 6'd0 : cnt_q;

	always_comb begin
		if (!busy_q) begin
			next_base = `IDCT_PRE_BASE;
		end else if (last_col) begin
			// jump down to the next block row
			next_base = blk_base_q + 18'd8 + 18'(7 * `IDCT_IMG_W);
		end else begin
			next_base = blk_base_q + 18'd8;
		end
		if (kick) begin
			iss_addr = next_base;
		end else if (cnt_q[2:0] == 3'd0) begin
			iss_addr = row_base_q + 18'(`IDCT_IMG_W);
		end else begin
			iss_addr = row_base_q + 18'(cnt_q[2:0]);
		end
	end

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			busy_q <= 1'b0;
			iss_on_q <= 1'b0;
			cnt_q <= 6'd0;
			blk_col_q <= 8'd0;
			blk_row_q <= 8'd0;
			blk_base_q <= `IDCT_PRE_BASE;
			row_base_q <= `IDCT_PRE_BASE;
			fetch_sram_addr_o <= `IDCT_PRE_BASE;
			dl_v_q <= 3'b000;
			fetch_done_o <= 1'b0;
			done_o <= 1'b0;
		end else begin
			dl_v_q <= {dl_v_q[1:0], iss_now};
			fetch_done_o <= dl_v_q[1] && (dl_idx_q[1] == 6'd63);
			done_o <= wb_done_i && busy_q && last_blk;
			if (wb_done_i && busy_q && last_blk) begin
				busy_q <= 1'b0;
			end
			if (kick) begin
				busy_q <= 1'b1;
				blk_base_q <= next_base;
				row_base_q <= next_base;
				blk_col_q <= (!busy_q || last_col) ? 8'd0 : blk_col_q + 8'd1;
				blk_row_q <= !busy_q ? 8'd0 : (last_col ? blk_row_q + 8'd1 : blk_row_q);
			end else if (iss_on_q && cnt_q[2:0] == 3'd0) begin
				row_base_q <= row_base_q + 18'(`IDCT_IMG_W);
			end
			if (iss_now) begin
				fetch_sram_addr_o <= iss_addr;
				cnt_q <= iss_idx + 6'd1;
				iss_on_q <= (iss_idx != 6'd63);
			end
		end
	end

	always_ff @(posedge Clock) begin
		dl_idx_q[0] <= iss_idx;
		dl_idx_q[1] <= dl_idx_q[0];
		dl_idx_q[2] <= dl_idx_q[1];
	end

	assign buf_we_o = dl_v_q[2];
	assign buf_waddr_o = dl_idx_q[2];
	assign buf_wdata_o = sram_rdata_i;

	// a new image may only start once the last one has finished
	a_no_start_busy: assert property (@(posedge Clock) disable iff (!Resetn)
		start_i |-> !busy_q);

endmodule

/* idct/idct_mac.sv */
// Two-pass 8x8 matrix multiply engine
`timescale 1ns/1ps
`include "idct_config.svh"

module idct_mac (
	input  logic            Clock,
	input  logic            Resetn,
	input  logic            fetch_done_i,
	input  logic            buf_we_i,
	input  logic [5:0]      buf_waddr_i,
	input  idct_pkg::coef_t buf_wdata_i,
	input  logic [5:0]      pix_raddr_i,
	output idct_pkg::coef_t pix_rdata_o,
	output logic            mac_done_o
);

	logic busy_q;
	logic pass2_q;
	logic [8:0] cnt_q;
	logic issue_v;
	logic [1:0] step;
	logic [2:0] k0;
	logic [2:0] k1;
	logic [2:0] c_sel;
	logic [5:0] rd_addr_a;
	logic [5:0] rd_addr_b;
	// pipeline: address, read, multiply, accumulate
	logic v1_q, v2_q, last3_q;
	logic [1:0] step1_q, step2_q;
	logic [5:0] ent1_q, ent2_q, ent3_q;
	idct_pkg::coef_t cv0_q, cv1_q;
	idct_pkg::acc_t op_a, op_b;
	logic signed [47:0] prod0_q, prod1_q, acc_q, s_full;
	idct_pkg::acc_t t_val;
	idct_pkg::coef_t pix_val;
	logic [6:0] coef_addr_a, coef_addr_b;
	logic coef_we_a;
	idct_pkg::coef_t coef_wdata_a, coef_rd_a, coef_rd_b;
	idct_pkg::acc_t t_rd_a, t_rd_b;

	assign issue_v = busy_q && !cnt_q[8];
	assign step = cnt_q[1:0];
	assign k0 = {step, 1'b0};
	assign k1 = {step, 1'b1};
	// pass 1 walks S' rows against C columns, pass 2 walks C columns against T columns
	assign c_sel = pass2_q ? cnt_q[7:5] : cnt_q[4:2];
	assign rd_addr_a = pass2_q ? {k0, cnt_q[4:2]} : {cnt_q[7:5], k0};
	assign rd_addr_b = pass2_q ? {k1, cnt_q[4:2]} : {cnt_q[7:5], k1};
	assign op_a = pass2_q ? t_rd_a : idct_pkg::acc_t'(coef_rd_a);
	assign op_b = pass2_q ? t_rd_b : idct_pkg::acc_t'(coef_rd_b);

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			busy_q <= 1'b0;
			pass2_q <= 1'b0;
			cnt_q <= 9'd0;
			mac_done_o <= 1'b0;
			v1_q <= 1'b0;
			v2_q <= 1'b0;
			last3_q <= 1'b0;
		end else begin
			mac_done_o <= busy_q && pass2_q && (cnt_q == 9'd258);
			v1_q <= issue_v;
			v2_q <= v1_q;
			last3_q <= v2_q && (step2_q == 2'd3);
			if (!busy_q) begin
				busy_q <= fetch_done_i;
				pass2_q <= 1'b0;
				cnt_q <= 9'd0;
			end else if (cnt_q == 9'd259) begin
				cnt_q <= 9'd0;
				busy_q <= !pass2_q;
				pass2_q <= !pass2_q;
			end else begin
				cnt_q <= cnt_q + 9'd1;
			end
		end
	end

	always_ff @(posedge Clock) begin
		step1_q <= step;
		ent1_q <= cnt_q[7:2];
		cv0_q <= idct_pkg::c_value(k0, c_sel);
		cv1_q <= idct_pkg::c_value(k1, c_sel);
		prod0_q <= op_a * cv0_q;
		prod1_q <= op_b * cv1_q;
		step2_q <= step1_q;
		ent2_q <= ent1_q;
		if (v2_q) begin
			acc_q <= (step2_q == 2'd0) ? prod0_q + prod1_q : acc_q + prod0_q + prod1_q;
			ent3_q <= ent2_q;
		end
	end

	always_comb begin
		t_val = idct_pkg::acc_t'(acc_q >>> `IDCT_T_SHIFT);
		s_full = acc_q >>> `IDCT_S_SHIFT;
		if (s_full < 0) begin
			pix_val = 16'sd0;
		end else if (s_full > 255) begin
			pix_val = 16'sd255;
		end else begin
			pix_val = idct_pkg::coef_t'(s_full[15:0]);
		end
	end

	// idle: port a takes fetch writes or the odd pixel, port b the even pixel
	always_comb begin
		if (busy_q) begin
			coef_addr_a = pass2_q ? {1'b1, ent3_q} : {1'b0, rd_addr_a};
			coef_we_a = pass2_q && last3_q;
			coef_wdata_a = pix_val;
			coef_addr_b = {1'b0, rd_addr_b};
		end else begin
			coef_addr_a = buf_we_i ? {1'b0, buf_waddr_i} : {1'b1, pix_raddr_i[5:1], 1'b1};
			coef_we_a = buf_we_i;
			coef_wdata_a = buf_wdata_i;
			coef_addr_b = {1'b1, pix_raddr_i[5:1], 1'b0};
		end
	end

	// even pixel in the upper byte
	assign pix_rdata_o = {coef_rd_b[7:0], coef_rd_a[7:0]};

	dp_ram #(.word_t(idct_pkg::coef_t), .DEPTH(128)) coef_ram (
		.Clock     (Clock),
		.addr_a_i  (coef_addr_a),
		.we_a_i    (coef_we_a),
		.wdata_a_i (coef_wdata_a),
		.rdata_a_o (coef_rd_a),
		.addr_b_i  (coef_addr_b),
		.we_b_i    (1'b0),
		.wdata_b_i (16'sd0),
		.rdata_b_o (coef_rd_b)
	);

	dp_ram #(.word_t(idct_pkg::acc_t), .DEPTH(64)) t_ram (
		.Clock     (Clock),
		.addr_a_i  (pass2_q ? rd_addr_a : ent3_q),
		.we_a_i    (busy_q && !pass2_q && last3_q),
		.wdata_a_i (t_val),
		.rdata_a_o (t_rd_a),
		.addr_b_i  (rd_addr_b),
		.we_b_i    (1'b0),
		.wdata_b_i (32'sd0),
		.rdata_b_o (t_rd_b)
	);

	// fetch must have finished the block before both passes run
	a_no_write_busy: assert property (@(posedge Clock) disable iff (!Resetn)
		busy_q |-> !buf_we_i);

endmodule

/* idct/idct_writeback.sv */
// Pixel writeback and SRAM port owner
`timescale 1ns/1ps
`include "idct_config.svh"

module idct_writeback (
	input  logic                  Clock,
	input  logic                  Resetn,
	input  logic                  mac_done_i,
	input  idct_pkg::coef_t       pix_rdata_i,
	output logic [5:0]            pix_raddr_o,
	input  idct_pkg::sram_addr_t  fetch_sram_addr_i,
	output idct_pkg::sram_addr_t  sram_addr_o,
	output logic                  sram_we_n_o,
	output logic [15:0]           sram_wdata_o,
	output logic                  wb_done_o
);

	logic rd_on_q;
	logic [4:0] rd_cnt_q;
	logic issue;
	logic [4:0] issue_pair;
	logic av_q;
	logic dv_q;
	logic [4:0] dpair_q;
	logic last_col;
	logic last_row;
	logic [7:0] blk_col_q;
	logic [7:0] blk_row_q;
	idct_pkg::sram_addr_t blk_base_q;
	idct_pkg::sram_addr_t row_base_q;
	idct_pkg::sram_addr_t wr_addr_q;

	assign issue = mac_done_i || rd_on_q;
	assign issue_pair = mac_done_i ? 5'd0 : rd_cnt_q;
	assign last_col = (blk_col_q == 8'(`IDCT_BLK_COLS - 1));
	assign last_row = (blk_row_q == 8'(`IDCT_BLK_ROWS - 1));

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			rd_on_q <= 1'b0;
			rd_cnt_q <= 5'd0;
			pix_raddr_o <= 6'd0;
			av_q <= 1'b0;
			dv_q <= 1'b0;
			sram_we_n_o <= 1'b1;
			wb_done_o <= 1'b0;
			blk_col_q <= 8'd0;
			blk_row_q <= 8'd0;
			blk_base_q <= `IDCT_OUT_BASE;
			row_base_q <= `IDCT_OUT_BASE;
		end else begin
			av_q <= issue;
			dv_q <= av_q;
			wb_done_o <= dv_q && (dpair_q == 5'd31);
			sram_we_n_o <= !dv_q;
			if (issue) begin
				pix_raddr_o <= {issue_pair, 1'b0};
				rd_cnt_q <= issue_pair + 5'd1;
				rd_on_q <= (issue_pair != 5'd31);
			end
			if (mac_done_i) begin
				row_base_q <= blk_base_q;
			end else if (dv_q && dpair_q[1:0] == 2'd3) begin
				row_base_q <= row_base_q + 18'(`IDCT_IMG_W / 2);
			end
			// step to the next block once its last pair is written
			if (dv_q && dpair_q == 5'd31) begin
				if (last_col && last_row) begin
					blk_base_q <= `IDCT_OUT_BASE;
					blk_col_q <= 8'd0;
					blk_row_q <= 8'd0;
				end else if (last_col) begin
					blk_base_q <= blk_base_q + 18'd4 + 18'(7 * (`IDCT_IMG_W / 2));
					blk_col_q <= 8'd0;
					blk_row_q <= blk_row_q + 8'd1;
				end else begin
					blk_base_q <= blk_base_q + 18'd4;
					blk_col_q <= blk_col_q + 8'd1;
				end
			end
		end
	end

	always_ff @(posedge Clock) begin
		dpair_q <= pix_raddr_o[5:1];
		if (dv_q) begin
			wr_addr_q <= row_base_q + 18'(dpair_q[1:0]);
			sram_wdata_o <= pix_rdata_i;
		end
	end

	assign sram_addr_o = sram_we_n_o ? fetch_sram_addr_i : wr_addr_q;

	// fetch must sit idle while pixels go out
	a_fetch_idle_on_write: assert property (@(posedge Clock) disable iff (!Resetn)
		!sram_we_n_o |-> $stable(fetch_sram_addr_i));

endmodule

/* verif/idct_patterns.txt */
// first 128 words: coefficients, 8 image rows of 16, each row split into its two blocks
// last 64 words: expected pixel words, 8 image rows of 8, even pixel in the upper byte
// row 0: block 0 is DC only, block 1 is DC plus the first horizontal harmonic
0400 0000 0000 0000 0000 0000 0000 0000
0400 03e8 0000 0000 0000 0000 0000 0000
// rows 1 to 7 are all zero
0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000
// expected pixels: block 0 flat at 127, block 1 columns 255 255 226 162 93 29 0 0
7f7f 7f7f 7f7f 7f7f ffff e2a2 5d1d 0000
7f7f 7f7f 7f7f 7f7f ffff e2a2 5d1d 0000
7f7f 7f7f 7f7f 7f7f ffff e2a2 5d1d 0000
7f7f 7f7f 7f7f 7f7f ffff e2a2 5d1d 0000
7f7f 7f7f 7f7f 7f7f ffff e2a2 5d1d 0000
7f7f 7f7f 7f7f 7f7f ffff e2a2 5d1d 0000
7f7f 7f7f 7f7f 7f7f ffff e2a2 5d1d 0000
7f7f 7f7f 7f7f 7f7f ffff e2a2 5d1d 0000

/* verif/tb_idct.sv */
// IDCT stage testbench
`timescale 1ns/1ps
`include "idct_config.svh"

module tb_idct;

	localparam int ROW_WORDS = `IDCT_IMG_W / 2;
	localparam int OUT_WORDS = ROW_WORDS * `IDCT_IMG_H;
	localparam int COEF_WORDS = `IDCT_IMG_W * `IDCT_IMG_H;
	localparam int PAT_WORDS = COEF_WORDS + OUT_WORDS;
	localparam int BLOCKS = `IDCT_BLK_COLS * `IDCT_BLK_ROWS;
	// fetch, two MAC passes and writeback per block, plus margin
	localparam int RUN_LIMIT = BLOCKS * (66 + 2 * (64 * 4 + 4) + 34) + 200;
	localparam int RUNS = 2;

	logic Clock = 1'b0;
	logic Resetn;
	logic start;
	idct_pkg::coef_t sram_rdata = '0;
	idct_pkg::sram_addr_t sram_addr;
	logic sram_we_n;
	logic [15:0] sram_wdata;
	logic done;

	logic [15:0] sram [0:(1 << 18) - 1];
	logic [15:0] pat_mem [0:PAT_WORDS - 1];
	idct_pkg::coef_t rd_pipe0 = '0;
	idct_pkg::coef_t rd_pipe1 = '0;
	int wr_hits [0:OUT_WORDS - 1];
	int wr_count = 0;
	int done_count = 0;

	idct_top dut0 (
		.Clock        (Clock),
		.Resetn       (Resetn),
		.start_i      (start),
		.sram_rdata_i (sram_rdata),
		.sram_addr_o  (sram_addr),
		.sram_we_n_o  (sram_we_n),
		.sram_wdata_o (sram_wdata),
		.done_o       (done)
	);

	always #5 Clock = ~Clock;

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Checks failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	function automatic logic [15:0] fill_word(input idct_pkg::sram_addr_t a);
		return a[15:0] ^ {a[17:16], 14'h0000} ^ 16'h5a3c;
	endfunction

	// two-cycle read latency, writes land on the falling edge
	always @(negedge Clock) begin
		rd_pipe0 <= sram[sram_addr];
		rd_pipe1 <= rd_pipe0;
		sram_rdata <= rd_pipe1;
		if (sram_we_n == 1'b0) begin
			sram[sram_addr] = sram_wdata;
		end
	end

	always @(negedge Clock) begin : write_monitor
		int off;
		if (Resetn) begin
			if (sram_we_n == 1'b0) begin
				off = int'(sram_addr) - int'(`IDCT_OUT_BASE);
				assert (off >= 0 && off < OUT_WORDS) else report_failure($sformatf(
					"ERR %0t: write to address %h outside the output region",
					$time, sram_addr));
				wr_hits[off] += 1;
				wr_count += 1;
			end
			if (done) begin
				// done only after the last write of the image
				assert (wr_count == OUT_WORDS * (done_count + 1)) else report_failure(
					$sformatf("ERR %0t: done_o after %0d writes, expected %0d",
					$time, wr_count, OUT_WORDS * (done_count + 1)));
				done_count += 1;
			end
		end
	end

	task automatic load_patterns();
		$readmemh("verif/idct_patterns.txt", pat_mem);
		assert (!$isunknown(pat_mem[PAT_WORDS - 1])) else report_failure(
			"pattern file verif/idct_patterns.txt is missing or too short");
	endtask

	task automatic preload_sram();
		int a;
		for (a = 0; a < (1 << 18); a++) begin
			sram[a] = fill_word(18'(a));
		end
		for (a = 0; a < COEF_WORDS; a++) begin
			sram[int'(`IDCT_PRE_BASE) + a] = pat_mem[a];
		end
	endtask

	// stale pixels from an earlier run must not survive
	task automatic clear_output();
		int a;
		for (a = int'(`IDCT_OUT_BASE); a < int'(`IDCT_OUT_BASE) + OUT_WORDS; a++) begin
			sram[a] = fill_word(18'(a));
		end
	endtask

	task automatic check_idle(input int cycles);
		repeat (cycles) begin
			@(negedge Clock);
			assert (sram_we_n === 1'b1 && done === 1'b0) else report_failure($sformatf(
				"ERR %0t: idle outputs we_n=%b done=%b", $time, sram_we_n, done));
		end
	endtask

	task automatic wait_for_done(input int target);
		int cycles;
		cycles = 0;
		while (done_count < target && cycles < RUN_LIMIT) begin
			@(posedge Clock);
			cycles++;
		end
		if (done_count < target) begin
			report_failure($sformatf("timeout, done_o did not pulse within %0d cycles",
				RUN_LIMIT));
		end
	endtask

	task automatic check_output(input int run);
		int r;
		int w;
		int idx;
		logic [15:0] got;
		logic [15:0] exp_word;
		for (r = 0; r < `IDCT_IMG_H; r++) begin
			for (w = 0; w < ROW_WORDS; w++) begin
				idx = r * ROW_WORDS + w;
				got = sram[int'(`IDCT_OUT_BASE) + idx];
				exp_word = pat_mem[COEF_WORDS + idx];
				assert (wr_hits[idx] == run) else report_failure($sformatf(
					"ERR %0t: word %0d written %0d times in %0d runs",
					$time, idx, wr_hits[idx], run));
				// even pixel sits in the upper byte
				assert (got[15:8] === exp_word[15:8]) else report_failure($sformatf(
					"ERR %0t: pixel row %0d col %0d got %0d expected %0d",
					$time, r, 2 * w, got[15:8], exp_word[15:8]));
				assert (got[7:0] === exp_word[7:0]) else report_failure($sformatf(
					"ERR %0t: pixel row %0d col %0d got %0d expected %0d",
					$time, r, 2 * w + 1, got[7:0], exp_word[7:0]));
			end
		end
	endtask

	initial begin
		int gap;
		int run;
		Resetn = 1'b0;
		start = 1'b0;
		void'($urandom(7236));
		load_patterns();
		preload_sram();
		repeat (2) @(negedge Clock);
		Resetn = 1'b1;
		for (run = 1; run <= RUNS; run++) begin
			if (run > 1) begin
				clear_output();
			end
			gap = $urandom_range(4, 20);
			check_idle(gap);
			start = 1'b1;
			@(negedge Clock);
			start = 1'b0;
			wait_for_done(run);
			check_output(run);
		end
		repeat (16) @(posedge Clock);
		assert (done_count == RUNS) else report_failure($sformatf(
			"ERR %0t: done_o pulsed %0d times for %0d runs", $time, done_count, RUNS));
		$display("All checks passed");
		$finish;
	end

endmodule

/* verilog/dp_ram.sv */
// Two-port synchronous RAM
`timescale 1ns/1ps

module dp_ram #(
	parameter type word_t = logic [15:0],
	parameter int DEPTH = 64
) (
	input  logic                     Clock,
	input  logic [$clog2(DEPTH)-1:0] addr_a_i,
	input  logic                     we_a_i,
	input  word_t                    wdata_a_i,
	output word_t                    rdata_a_o,
	input  logic [$clog2(DEPTH)-1:0] addr_b_i,
	input  logic                     we_b_i,
	input  word_t                    wdata_b_i,
	output word_t                    rdata_b_o
);

	word_t mem [DEPTH];

	always_ff @(posedge Clock) begin
		if (we_a_i) begin
			mem[addr_a_i] <= wdata_a_i;
		end
		if (we_b_i) begin
			mem[addr_b_i] <= wdata_b_i;
		end
		rdata_a_o <= mem[addr_a_i];
		rdata_b_o <= mem[addr_b_i];
	end

endmodule

/* verilog/idct_top.sv */
// IDCT stage top level
`timescale 1ns/1ps

module idct_top (
	input  logic                  Clock,
	input  logic                  Resetn,
	input  logic                  start_i,
	input  idct_pkg::coef_t       sram_rdata_i,
	output idct_pkg::sram_addr_t  sram_addr_o,
	output logic                  sram_we_n_o,
	output logic [15:0]           sram_wdata_o,
	output logic                  done_o
);

	logic buf_we;
	logic [5:0] buf_waddr;
	idct_pkg::coef_t buf_wdata;
	logic fetch_done;
	logic mac_done;
	logic wb_done;
	logic [5:0] pix_raddr;
	idct_pkg::coef_t pix_rdata;
	idct_pkg::sram_addr_t fetch_sram_addr;

	idct_block_fetch fetch0 (
		.Clock             (Clock),
		.Resetn            (Resetn),
		.start_i           (start_i),
		.wb_done_i         (wb_done),
		.sram_rdata_i      (sram_rdata_i),
		.fetch_sram_addr_o (fetch_sram_addr),
		.buf_we_o          (buf_we),
		.buf_waddr_o       (buf_waddr),
		.buf_wdata_o       (buf_wdata),
		.fetch_done_o      (fetch_done),
		.done_o            (done_o)
	);

	idct_mac mac0 (
		.Clock        (Clock),
		.Resetn       (Resetn),
		.fetch_done_i (fetch_done),
		.buf_we_i     (buf_we),
		.buf_waddr_i  (buf_waddr),
		.buf_wdata_i  (buf_wdata),
		.pix_raddr_i  (pix_raddr),
		.pix_rdata_o  (pix_rdata),
		.mac_done_o   (mac_done)
	);

	idct_writeback wb0 (
		.Clock             (Clock),
		.Resetn            (Resetn),
		.mac_done_i        (mac_done),
		.pix_rdata_i       (pix_rdata),
		.pix_raddr_o       (pix_raddr),
		.fetch_sram_addr_i (fetch_sram_addr),
		.sram_addr_o       (sram_addr_o),
		.sram_we_n_o       (sram_we_n_o),
		.sram_wdata_o      (sram_wdata_o),
		.wb_done_o         (wb_done)
	);

endmodule
